/* Bender.yml */
package:
  name: exec_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/ariane_pkg.sv
      - source/fu_req_if.sv
      - source/alu.sv
      - source/branch_unit.sv
      - source/exec_regs.sv
      - source/alu_ctrl_fsm.sv
      - source/retire_counter.sv
      - source/exec_unit.sv
  - target: simulation
    files:
      - sim/exec_unit_props.sv
      - sim/tb_exec_unit.sv

/* project.f */
+incdir+source
source/ariane_pkg.sv
source/fu_req_if.sv
source/alu.sv
source/branch_unit.sv
source/exec_regs.sv
source/alu_ctrl_fsm.sv
source/retire_counter.sv
source/exec_unit.sv
sim/exec_unit_props.sv
sim/tb_exec_unit.sv

/* sim/exec_unit_props.sv */
// ----------------------------------------------------------
// handshake and hold checks for the execute unit
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module exec_unit_props (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             req_i,
  input logic             ack_i,
  input logic [`XLEN-1:0] result_i,
  input logic [`XLEN-1:0] target_i,
  input logic             taken_i
);

  // number of failed assertions
  int fail_cnt = 0;

  // ack loads on the second edge after acceptance and is sampled one edge later
  ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_i) |-> ##3 $rose(ack_i))
  else
  begin
    fail_cnt++;
    $error("ack did not rise 2 cycles after the request was accepted");
  end

  // ack only goes up under an active request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i))
  else
  begin
    fail_cnt++;
    $error("ack rose while req was low");
  end

  // results frozen for the whole ack phase
  hold_results: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i && $past(ack_i) |-> $stable(result_i) && $stable(target_i) && $stable(taken_i))
  else
  begin
    fail_cnt++;
    $error("results changed while ack was high");
  end

endmodule

bind exec_unit exec_unit_props u_props (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .result_i (result_o),
  .target_i (branch_target_o),
  .taken_i  (branch_taken_o)
);

/* sim/tb_exec_unit.sv */
// ----------------------------------------------------------
// testbench for the integer execute unit
// directed ops over the req/ack port against a reference model
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module tb_exec_unit;
  import ariane_pkg::*;

  // arith 7x7, shifts 6x6, compares 6x8, held ops 3
  localparam int NUM_OPS    = 136;
  // about 5 cycles per op plus slack for reset and held ops
  localparam int MAX_CYCLES = NUM_OPS * 8 + 100;

  typedef logic [`XLEN-1:0] word_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              req_i;
  logic              ack_o;
  fu_op              operator_i;
  word_t             operand_a_i;
  word_t             operand_b_i;
  word_t             pc_i;
  word_t             imm_i;
  word_t             result_o;
  word_t             branch_target_o;
  logic              branch_taken_o;
  logic [`CNT_W-1:0] retired_o;
  logic [`CNT_W-1:0] taken_cnt_o;

  int                err_cnt;
  int                test_cnt;
  int                cycle_cnt;
  logic [`CNT_W-1:0] exp_retired;
  logic [`CNT_W-1:0] exp_taken;

  // ----------------------------------------------------------
  // directed operand sets
  // ----------------------------------------------------------
  fu_op  arith_ops[$] = '{ADD, SUB, ADDW, SUBW, ANDL, ORL, XORL};
  // zero, all ones, 32-bit overflow, sign boundary
  word_t arith_a[$]   = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_7fff_ffff,
                          64'h8000_0000_0000_0000};
  word_t arith_b[$]   = '{64'h0, 64'h1, 64'h1, 64'hffff_ffff_ffff_ffff};
  fu_op  shift_ops[$] = '{SLL, SRL, SRA, SLLW, SRLW, SRAW};
  // sign set in both the double word and the low word
  word_t shift_a[$]   = '{64'h8765_4321_f0f0_0f0f, 64'h8765_4321_f0f0_0f0f,
                          64'h8765_4321_f0f0_0f0f, 64'h8765_4321_f0f0_0f0f};
  word_t shift_b[$]   = '{64'd0, 64'd31, 64'd32, 64'd63};
  fu_op  cmp_ops[$]   = '{EQ, NE, LTS, LTU, GES, GEU};
  word_t cmp_a[$]     = '{64'd5, 64'd1, 64'd2, 64'hffff_ffff_ffff_ffff, 64'd1,
                          64'h8000_0000_0000_0000};
  word_t cmp_b[$]     = '{64'd5, 64'd2, 64'd1, 64'd1, 64'hffff_ffff_ffff_ffff,
                          64'h7fff_ffff_ffff_ffff};

  exec_unit dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // watchdog
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: handshake did not complete, run stopped after %0d cycles", cycle_cnt);
    $display("TESTS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic word_t sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic word_t model_result(input fu_op op, input word_t a, input word_t b);
    word_t r;
    r = '0;
    case (op)
      ADD:  r = a + b;
      SUB:  r = a - b;
      ADDW: r = sext_word(a[31:0] + b[31:0]);
      SUBW: r = sext_word(a[31:0] - b[31:0]);
      ANDL: r = a & b;
      ORL:  r = a | b;
      XORL: r = a ^ b;
      SLL:  r = a << b[5:0];
      SRL:  r = a >> b[5:0];
      SRA:  r = $signed(a) >>> b[5:0];
      // word shifts see 5 amount bits
      SLLW: r = sext_word(a[31:0] << b[4:0]);
      SRLW: r = sext_word(a[31:0] >> b[4:0]);
      SRAW: r = sext_word($signed(a[31:0]) >>> b[4:0]);
      EQ:   r[0] = (a == b);
      NE:   r[0] = (a != b);
      LTS:  r[0] = ($signed(a) < $signed(b));
      LTU:  r[0] = (a < b);
      GES:  r[0] = ($signed(a) >= $signed(b));
      GEU:  r[0] = (a >= b);
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic model_taken(input fu_op op, input word_t a, input word_t b);
    word_t r;
    r = model_result(op, a, b);
    return is_branch_op(op) && r[0];
  endfunction

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic cmp_word(input string name, input logic [`XLEN-1:0] got,
                          input logic [`XLEN-1:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic cmp_count(input string name, input logic [`CNT_W-1:0] got,
                           input logic [`CNT_W-1:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_outputs(input word_t res, input logic tkn, input word_t tgt);
    cmp_word("result_o", result_o, res);
    cmp_bit("branch_taken_o", branch_taken_o, tkn);
    cmp_word("branch_target_o", branch_target_o, tgt);
    cmp_count("retired_o", retired_o, exp_retired);
    cmp_count("taken_cnt_o", taken_cnt_o, exp_taken);
  endtask

  // ----------------------------------------------------------
  // one four-phase transaction
  // ----------------------------------------------------------
  task automatic do_op(input fu_op op, input word_t a, input word_t b, input int hold);
    word_t exp_res;
    word_t exp_tgt;
    word_t pc;
    word_t imm;
    logic  exp_tkn;
    int    waited;
    int    errs_before;
    int    k;
    pc          = rand_word();
    imm         = rand_word();
    exp_res     = model_result(op, a, b);
    exp_tkn     = model_taken(op, a, b);
    exp_tgt     = exp_tkn ? pc + imm : pc + `INSN_STEP;
    errs_before = err_cnt;
    @(negedge clk_i);
    operator_i  = op;
    operand_a_i = a;
    operand_b_i = b;
    pc_i        = pc;
    imm_i       = imm;
    req_i       = 1'b1;
    waited      = 0;
    do
    begin
      @(negedge clk_i);
      waited++;
    end
    while (!ack_o);
    // first edge accepts, ack follows two edges later
    if (waited != 3)
    begin
      err_cnt++;
      $display("%s: ack_o rose %0d cycles after the request was taken, not 2",
               op.name(), waited - 1);
    end
    exp_retired++;
    if (exp_tkn)
      exp_taken++;
    check_outputs(exp_res, exp_tkn, exp_tgt);
    // inputs move under back-pressure while the results hold
    for (k = 0; k < hold; k++)
    begin
      @(negedge clk_i);
      operand_a_i = rand_word();
      cmp_bit("ack_o", ack_o, 1'b1);
      check_outputs(exp_res, exp_tkn, exp_tgt);
    end
    req_i = 1'b0;
    do
    begin
      @(negedge clk_i);
    end
    while (ack_o);
    test_cnt++;
    $display("%-5s a=%h b=%h %s", op.name(), a, b,
             (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  // corner pairs, then random pairs
  task automatic run_set(input fu_op op, input word_t av[$], input word_t bv[$],
                         input int n_rand);
    int i;
    for (i = 0; i < av.size(); i++)
      do_op(op, av[i], bv[i], 0);
    for (i = 0; i < n_rand; i++)
      do_op(op, rand_word(), rand_word(), 0);
  endtask

  initial
  begin
    void'($urandom(32'h2877));
    err_cnt     = 0;
    test_cnt    = 0;
    exp_retired = '0;
    exp_taken   = '0;
    rst_n_i     = 1'b0;
    req_i       = 1'b0;
    operator_i  = ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    pc_i        = '0;
    imm_i       = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // state right out of reset
    cmp_bit("ack_o", ack_o, 1'b0);
    cmp_word("result_o", result_o, '0);
    cmp_count("retired_o", retired_o, '0);
    cmp_count("taken_cnt_o", taken_cnt_o, '0);
    test_cnt++;
    $display("reset %s", (err_cnt == 0) ? "ok" : "mismatch");

    foreach (arith_ops[i])
      run_set(arith_ops[i], arith_a, arith_b, 3);
    foreach (shift_ops[i])
      run_set(shift_ops[i], shift_a, shift_b, 2);
    foreach (cmp_ops[i])
      run_set(cmp_ops[i], cmp_a, cmp_b, 2);

    // req held high over a taken branch, a plain op and a not-taken branch
    do_op(EQ, 64'h1234, 64'h1234, 5);
    do_op(ADD, rand_word(), rand_word(), 5);
    do_op(LTU, 64'h9, 64'h3, 5);
    cmp_count("retired_o", retired_o, NUM_OPS);
    cmp_count("taken_cnt_o", taken_cnt_o, exp_taken);

    // add failures of the bound handshake assertions
    err_cnt += dut_i.u_props.fail_cnt;

    $display("%0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* source/alu.sv */
// ----------------------------------------------------------
// 64-bit integer alu, purely combinational
// adder, bit-reversal shifter, comparator and result mux
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module alu (
  fu_req_if.fu             fu,
  output logic [`XLEN-1:0] result_o,
  output logic             comparison_result_o
);
  import ariane_pkg::*;

  logic [`XLEN-1:0] operand_a_rev;
  logic [31:0]      operand_a_rev32;

  // bit reversed copies of operand a, left shifts reuse the right shifter
  always_comb
  begin
    for (int k = 0; k < `XLEN; k++)
      operand_a_rev[k] = fu.operand_a[`XLEN-1-k];
    for (int k = 0; k < 32; k++)
      operand_a_rev32[k] = fu.operand_a[31-k];
  end

  // ----------------------------------------------------------
  // adder
  // ----------------------------------------------------------
  logic             adder_negate;
  logic [`XLEN:0]   adder_in_a;
  logic [`XLEN:0]   adder_in_b;
  logic [`XLEN:0]   adder_sum;
  logic [`XLEN-1:0] adder_result;

  assign adder_negate = is_negate_op(fu.operator);

  // extra lsb on both sides, 1 + 1 gives the +1 of the two's complement
  assign adder_in_a   = {fu.operand_a, 1'b1};
  assign adder_in_b   = {fu.operand_b, 1'b0} ^ {(`XLEN+1){adder_negate}};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[`XLEN:1];

  // ----------------------------------------------------------
  // shifter
  // ----------------------------------------------------------
  logic             shift_left;
  logic             shift_arith;
  logic [`XLEN-1:0] shift_op_a;
  logic [31:0]      shift_op_a32;
  logic [`XLEN:0]   shift_right_result;
  logic [32:0]      shift_right_result32;
  logic [`XLEN-1:0] shift_left_result;
  logic [31:0]      shift_left_result32;
  logic [`XLEN-1:0] shift_result;
  logic [31:0]      shift_result32;

  assign shift_left  = (fu.operator == SLL) || (fu.operator == SLLW);
  assign shift_arith = (fu.operator == SRA) || (fu.operator == SRAW);

  // reversed input for left shifts
  assign shift_op_a   = shift_left ? operand_a_rev : fu.operand_a;
  assign shift_op_a32 = shift_left ? operand_a_rev32 : fu.operand_a[31:0];

  // extra top bit carries the sign only for arithmetic shifts
  // word forms look at the low 5 amount bits only
  assign shift_right_result =
    $signed({shift_arith & shift_op_a[`XLEN-1], shift_op_a}) >>> fu.operand_b[5:0];
  assign shift_right_result32 =
    $signed({shift_arith & shift_op_a32[31], shift_op_a32}) >>> fu.operand_b[4:0];

  // reverse back to get the left shift
  always_comb
  begin
    for (int k = 0; k < `XLEN; k++)
      shift_left_result[k] = shift_right_result[`XLEN-1-k];
    for (int k = 0; k < 32; k++)
      shift_left_result32[k] = shift_right_result32[31-k];
  end

  assign shift_result   = shift_left ? shift_left_result : shift_right_result[`XLEN-1:0];
  assign shift_result32 = shift_left ? shift_left_result32 : shift_right_result32[31:0];

  // ----------------------------------------------------------
  // comparator
  // ----------------------------------------------------------
  logic is_equal;
  logic is_greater_equal;
  logic cmp_signed;

  assign cmp_signed = is_signed_cmp(fu.operator);
  assign is_equal   = (adder_result == '0);

  // same sign: a - b sign decides
  // different sign: a's msb decides, flipped for signed compares
  always_comb
  begin
    if (fu.operand_a[`XLEN-1] == fu.operand_b[`XLEN-1])
      is_greater_equal = ~adder_result[`XLEN-1];
    else
      is_greater_equal = fu.operand_a[`XLEN-1] ^ cmp_signed;
  end

  always_comb
  begin
    comparison_result_o = 1'b0;
    unique case (fu.operator)
      EQ:                       comparison_result_o = is_equal;
      NE:                       comparison_result_o = ~is_equal;
      GES, GEU:                 comparison_result_o = is_greater_equal;
      LTS, LTU, SLETS, SLETU:   comparison_result_o = ~is_greater_equal;
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // result mux
  // ----------------------------------------------------------
  always_comb
  begin
    result_o = '0;
    unique case (fu.operator)
      ANDL:             result_o = fu.operand_a & fu.operand_b;
      ORL:              result_o = fu.operand_a | fu.operand_b;
      XORL:             result_o = fu.operand_a ^ fu.operand_b;
      ADD, SUB:         result_o = adder_result;
      // word ops keep the low half, sign extended
      ADDW, SUBW:       result_o = {{32{adder_result[31]}}, adder_result[31:0]};
      SLL, SRL, SRA:    result_o = shift_result;
      SLLW, SRLW, SRAW: result_o = {{32{shift_result32[31]}}, shift_result32};
      // compare flag in bit 0
      EQ, NE, LTS, LTU, GES, GEU, SLETS, SLETU:
        result_o = {{(`XLEN-1){1'b0}}, comparison_result_o};
      default: ;
    endcase
  end

endmodule

/* source/alu_ctrl_fsm.sv */
// ----------------------------------------------------------
// four-phase req/ack sequencer
// idle, exec, ack with one-cycle capture and commit strobes
// ----------------------------------------------------------
`timescale 1ns/1ns

module alu_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic req_i,
  output logic ack_o,
  output logic capture_o,
  output logic commit_o
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK
  } state_e;

  state_e state_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= IDLE;
      ack_o     <= 1'b0;
      capture_o <= 1'b0;
      commit_o  <= 1'b0;
    end
    else
    begin
      // strobes are single-cycle pulses
      capture_o <= 1'b0;
      commit_o  <= 1'b0;
      unique case (state_q)
        // new request latched on the next edge
        IDLE:
          if (req_i)
          begin
            capture_o <= 1'b1;
            state_q   <= EXEC;
          end
        // operands are in, alu settles, load results next edge
        EXEC:
        begin
          commit_o <= 1'b1;
          state_q  <= ACK;
        end
        // ack goes up with the results, down once req drops
        ACK:
          if (commit_o)
            ack_o <= 1'b1;
          else if (!req_i)
          begin
            ack_o   <= 1'b0;
            state_q <= IDLE;
          end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* source/ariane_consts.svh */
// ----------------------------------------------------------
// execute unit constants
// data path width, retire counter width, pc step
// ----------------------------------------------------------
`ifndef ARIANE_CONSTS_SVH
`define ARIANE_CONSTS_SVH

// data path width
`define XLEN 64

// width of each retire counter, wraps on overflow
`define CNT_W 32

// pc increment of a not-taken branch
`define INSN_STEP 4

`endif

/* source/ariane_pkg.sv */
// ----------------------------------------------------------
// execute unit package
// alu operator encoding and operator class helpers
// ----------------------------------------------------------
package ariane_pkg;

  // alu operators, ADD is the reset value
  typedef enum logic [6:0] {
    ADD, SUB, ADDW, SUBW,
    ANDL, ORL, XORL,
    SLL, SRL, SRA, SLLW, SRLW, SRAW,
    EQ, NE, LTS, LTU, GES, GEU, SLETS, SLETU
  } fu_op;

  // conditional branch compares
  function automatic logic is_branch_op(input fu_op op);
    return op inside {EQ, NE, LTS, LTU, GES, GEU};
  endfunction

  // ops that run the adder as a - b
  function automatic logic is_negate_op(input fu_op op);
    return op inside {SUB, SUBW, EQ, NE, LTS, LTU, GES, GEU, SLETS, SLETU};
  endfunction

  // compares that treat the operands as two's complement
  function automatic logic is_signed_cmp(input fu_op op);
    return op inside {LTS, GES, SLETS};
  endfunction

endpackage

/* source/branch_unit.sv */
// ----------------------------------------------------------
// branch resolution
// taken flag and next pc from the alu compare
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module branch_unit (
  fu_req_if.fu             fu,
  input  logic             comparison_result_i,
  output logic             taken_o,
  output logic [`XLEN-1:0] target_o
);
  import ariane_pkg::*;

  // fall-through step
  localparam logic [`XLEN-1:0] insn_step = `INSN_STEP;

  logic [`XLEN-1:0] pc_offset;

  // non-branch ops never take
  assign taken_o = is_branch_op(fu.operator) & comparison_result_i;

  // pc + imm when taken, else next insn
  assign pc_offset = taken_o ? fu.imm : insn_step;
  assign target_o  = fu.pc + pc_offset;

endmodule

/* source/exec_regs.sv */
// ----------------------------------------------------------
// operand capture and result registers
// loaded on the capture and commit strobes
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module exec_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               capture_i,
  input  logic               commit_i,
  input  ariane_pkg::fu_op   operator_i,
  input  logic [`XLEN-1:0]   operand_a_i,
  input  logic [`XLEN-1:0]   operand_b_i,
  input  logic [`XLEN-1:0]   pc_i,
  input  logic [`XLEN-1:0]   imm_i,
  fu_req_if.regs             fu,
  input  logic [`XLEN-1:0]   result_i,
  input  logic [`XLEN-1:0]   target_i,
  input  logic               taken_i,
  output logic [`XLEN-1:0]   result_o,
  output logic [`XLEN-1:0]   target_o,
  output logic               taken_o
);
  import ariane_pkg::*;

  // request side, held for the whole operation
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      fu.operator  <= ADD;
      fu.operand_a <= '0;
      fu.operand_b <= '0;
      fu.pc        <= '0;
      fu.imm       <= '0;
    end
    else if (capture_i)
    begin
      fu.operator  <= operator_i;
      fu.operand_a <= operand_a_i;
      fu.operand_b <= operand_b_i;
      fu.pc        <= pc_i;
      fu.imm       <= imm_i;
    end
  end

  // result side, stable while ack is up
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      result_o <= '0;
      target_o <= '0;
      taken_o  <= 1'b0;
    end
    else if (commit_i)
    begin
      result_o <= result_i;
      target_o <= target_i;
      taken_o  <= taken_i;
    end
  end

endmodule

/* source/exec_unit.sv */
// ----------------------------------------------------------
// integer execute unit top
// req/ack port, operand regs, alu, branch unit, counters
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module exec_unit (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  output logic              ack_o,
  input  ariane_pkg::fu_op  operator_i,
  input  logic [`XLEN-1:0]  operand_a_i,
  input  logic [`XLEN-1:0]  operand_b_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  logic [`XLEN-1:0]  imm_i,
  output logic [`XLEN-1:0]  result_o,
  output logic [`XLEN-1:0]  branch_target_o,
  output logic              branch_taken_o,
  output logic [`CNT_W-1:0] retired_o,
  output logic [`CNT_W-1:0] taken_cnt_o
);

  // controller strobes
  logic capture;
  logic commit;

  // combinational results ahead of the result register
  logic [`XLEN-1:0] alu_result;
  logic             cmp_result;
  logic             bu_taken;
  logic [`XLEN-1:0] bu_target;

  // latched request
  fu_req_if fu_req ();

  alu_ctrl_fsm u_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .capture_o (capture),
    .commit_o  (commit)
  );

  exec_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .capture_i   (capture),
    .commit_i    (commit),
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .pc_i        (pc_i),
    .imm_i       (imm_i),
    .fu          (fu_req.regs),
    .result_i    (alu_result),
    .target_i    (bu_target),
    .taken_i     (bu_taken),
    .result_o    (result_o),
    .target_o    (branch_target_o),
    .taken_o     (branch_taken_o)
  );

  alu u_alu (
    .fu                  (fu_req.fu),
    .result_o            (alu_result),
    .comparison_result_o (cmp_result)
  );

  branch_unit u_branch (
    .fu                  (fu_req.fu),
    .comparison_result_i (cmp_result),
    .taken_o             (bu_taken),
    .target_o            (bu_target)
  );

  // counts on the commit edge, with the flag being committed
  retire_counter u_retire (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .commit_i    (commit),
    .taken_i     (bu_taken),
    .retired_o   (retired_o),
    .taken_cnt_o (taken_cnt_o)
  );

endmodule

/* source/fu_req_if.sv */
// ----------------------------------------------------------
// latched execute request
// operand register to alu and branch unit
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

interface fu_req_if;
  import ariane_pkg::*;

  fu_op              operator;
  logic [`XLEN-1:0]  operand_a;
  logic [`XLEN-1:0]  operand_b;
  // branch base and offset
  logic [`XLEN-1:0]  pc;
  logic [`XLEN-1:0]  imm;

  // operand register side
  modport regs (output operator, operand_a, operand_b, pc, imm);

  // read-only view for alu and branch unit
  modport fu (input operator, operand_a, operand_b, pc, imm);

endinterface

/* source/retire_counter.sv */
// ----------------------------------------------------------
// retire statistics
// committed ops and taken branches, both wrap
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "ariane_consts.svh"

module retire_counter (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              commit_i,
  input  logic              taken_i,
  output logic [`CNT_W-1:0] retired_o,
  output logic [`CNT_W-1:0] taken_cnt_o
);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      retired_o   <= '0;
      taken_cnt_o <= '0;
    end
    else if (commit_i)
    begin
      retired_o <= retired_o + 1'b1;
      // taken flag of the op being committed
      if (taken_i)
        taken_cnt_o <= taken_cnt_o + 1'b1;
    end
  end

endmodule
